//--- source/ucode_pkg.sv
package ucode_pkg;

  localparam int opcode_w    = 16;
  localparam int rom_entry_w = 4;
  localparam int step_w      = 2;  // up to four micro-ops per entry.
  localparam int queue_depth = 4;
  localparam int out_credits = 4;

  // counters hold values up to the larger credit pool.
  localparam int credit_w = $clog2((queue_depth > out_credits ? queue_depth : out_credits) + 1);
  localparam int ptr_w    = $clog2(queue_depth);

  typedef logic [credit_w-1:0] credit_t;
  typedef logic [ptr_w-1:0]    ptr_t;
  typedef logic [step_w-1:0]   step_t;

  typedef enum logic [2:0] {
    uop_direct,
    uop_load,
    uop_store,
    uop_alu,
    uop_push,
    uop_pop,
    uop_jump
  } uop_kind_e;

  typedef struct packed {
    uop_kind_e             kind;
    logic [opcode_w-1:0]   opcode;  // full opcode field, low byte included.
    logic                  last;    // final micro-op of the instruction.
  } uop_t;

  typedef struct packed {
    uop_kind_e kind;
    logic      last;
  } rom_word_t;

  typedef enum logic [1:0] {
    seq_idle,
    seq_direct,
    seq_rom
  } seq_state_e;

endpackage

//--- source/opcode_rom_control_cloud.sv
`timescale 1ns/10ps

module opcode_rom_control_cloud (
  input  logic [ucode_pkg::opcode_w-1:0]    opcode,
  input  logic                              sizeop,
  output logic [ucode_pkg::rom_entry_w-1:0] rom_control,
  output logic                              rom_in_control
);

  logic [7:0]  hi;
  logic [15:0] term;

  assign hi = opcode[15:8];  // low byte takes no part in the decision.

  // product terms, sized ones qualified by sizeop low.
  assign term[0]  = (hi == 8'hE8);
  assign term[1]  = (hi == 8'hFF);
  assign term[2]  = !sizeop && (hi ==? 8'b1100_x01x);
  assign term[3]  = !sizeop && (hi == 8'h9A);
  assign term[4]  = !sizeop && (hi == 8'hCF);
  assign term[5]  = (hi == 8'hFF);
  assign term[6]  = !sizeop && (hi ==? 8'b1100_x010);
  assign term[7]  = !sizeop && (hi == 8'hFF);
  assign term[8]  = !sizeop && (hi == 8'hE8);
  assign term[9]  = !sizeop && (hi == 8'h9A);
  assign term[10] = !sizeop && (hi ==? 8'b1100_101x);
  assign term[11] = (hi == 8'hE8);
  assign term[12] = !sizeop && (hi == 8'h9A);
  assign term[13] = !sizeop && (hi == 8'hCF);
  assign term[14] = (hi == 8'hFF);
  assign term[15] = !sizeop && (hi ==? 8'b1100_x01x);

  assign rom_control[3] = term[0] | term[1];
  assign rom_control[2] = term[2];
  assign rom_control[1] = term[3] | term[4] | term[5] | term[6];
  assign rom_control[0] = term[7] | term[8] | term[9] | term[10];

  assign rom_in_control = term[11] | term[12] | term[13] | term[14] | term[15];

endmodule

//--- source/ucode_rom.sv
`timescale 1ns/10ps

module ucode_rom (
  input  logic [ucode_pkg::rom_entry_w-1:0] entry,
  input  logic [ucode_pkg::step_w-1:0]      step,
  output ucode_pkg::rom_word_t              word
);

  always_comb begin
    word = '{ucode_pkg::uop_alu, 1'b1};  // unused slots end the sequence.
    case ({entry, step})
      // entry 2, CF.
      {4'h2, 2'd0}: word = '{ucode_pkg::uop_pop, 1'b0};
      {4'h2, 2'd1}: word = '{ucode_pkg::uop_pop, 1'b0};
      {4'h2, 2'd2}: word = '{ucode_pkg::uop_pop, 1'b0};
      {4'h2, 2'd3}: word = '{ucode_pkg::uop_jump, 1'b1};
      // entry 3, 9A.
      {4'h3, 2'd0}: word = '{ucode_pkg::uop_push, 1'b0};
      {4'h3, 2'd1}: word = '{ucode_pkg::uop_push, 1'b0};
      {4'h3, 2'd2}: word = '{ucode_pkg::uop_jump, 1'b1};
      // entry 4, C3.
      {4'h4, 2'd0}: word = '{ucode_pkg::uop_pop, 1'b0};
      {4'h4, 2'd1}: word = '{ucode_pkg::uop_jump, 1'b1};
      // entry 5, CB.
      {4'h5, 2'd0}: word = '{ucode_pkg::uop_pop, 1'b0};
      {4'h5, 2'd1}: word = '{ucode_pkg::uop_pop, 1'b0};
      {4'h5, 2'd2}: word = '{ucode_pkg::uop_jump, 1'b1};
      // entry 6, C2.
      {4'h6, 2'd0}: word = '{ucode_pkg::uop_pop, 1'b0};
      {4'h6, 2'd1}: word = '{ucode_pkg::uop_alu, 1'b0};
      {4'h6, 2'd2}: word = '{ucode_pkg::uop_jump, 1'b1};
      // entry 7, CA.
      {4'h7, 2'd0}: word = '{ucode_pkg::uop_pop, 1'b0};
      {4'h7, 2'd1}: word = '{ucode_pkg::uop_pop, 1'b0};
      {4'h7, 2'd2}: word = '{ucode_pkg::uop_alu, 1'b0};
      {4'h7, 2'd3}: word = '{ucode_pkg::uop_jump, 1'b1};
      // entry 8, E8 with sizeop high.
      {4'h8, 2'd0}: word = '{ucode_pkg::uop_push, 1'b0};
      {4'h8, 2'd1}: word = '{ucode_pkg::uop_jump, 1'b1};
      // entry 9, E8 with sizeop low.
      {4'h9, 2'd0}: word = '{ucode_pkg::uop_alu, 1'b0};
      {4'h9, 2'd1}: word = '{ucode_pkg::uop_push, 1'b0};
      {4'h9, 2'd2}: word = '{ucode_pkg::uop_jump, 1'b1};
      // entry a, FF with sizeop high.
      {4'hA, 2'd0}: word = '{ucode_pkg::uop_load, 1'b0};
      {4'hA, 2'd1}: word = '{ucode_pkg::uop_push, 1'b0};
      {4'hA, 2'd2}: word = '{ucode_pkg::uop_jump, 1'b1};
      // entry b, FF with sizeop low.
      {4'hB, 2'd0}: word = '{ucode_pkg::uop_load, 1'b0};
      {4'hB, 2'd1}: word = '{ucode_pkg::uop_alu, 1'b0};
      {4'hB, 2'd2}: word = '{ucode_pkg::uop_push, 1'b0};
      {4'hB, 2'd3}: word = '{ucode_pkg::uop_jump, 1'b1};
      // entry c, spare store slot.
      {4'hC, 2'd0}: word = '{ucode_pkg::uop_store, 1'b1};
      default: ;
    endcase
  end

endmodule

//--- source/uop_credit_if.sv
`timescale 1ns/10ps

interface uop_credit_if;

  logic            valid;
  ucode_pkg::uop_t uop;
  logic            credit_return;  // one pulse per entry leaving the queue.

  modport sender (
    output valid,
    output uop,
    input  credit_return
  );

  modport receiver (
    input  valid,
    input  uop,
    output credit_return
  );

endinterface

//--- source/ucode_sequencer.sv
`timescale 1ns/10ps

module ucode_sequencer (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           in_valid,
  input  logic [ucode_pkg::opcode_w-1:0] in_opcode,
  input  logic                           in_sizeop,
  output logic                           in_ready,
  uop_credit_if.sender                   tx
);

  logic [ucode_pkg::opcode_w-1:0]    op_q;
  logic                              size_q;
  logic                              busy_q;
  logic                              ready_q;
  ucode_pkg::step_t                  step_q;
  ucode_pkg::credit_t                cred_q;
  ucode_pkg::credit_t                cred_d;
  ucode_pkg::seq_state_e             state;
  logic [ucode_pkg::rom_entry_w-1:0] rom_control;
  logic                              rom_in_control;
  ucode_pkg::rom_word_t              word;
  ucode_pkg::uop_t                   uop;
  logic                              accept;
  logic                              send;
  logic                              done;

  opcode_rom_control_cloud u_cloud (
    .opcode         (op_q),
    .sizeop         (size_q),
    .rom_control    (rom_control),
    .rom_in_control (rom_in_control)
  );

  ucode_rom u_rom (
    .entry (rom_control),
    .step  (step_q),
    .word  (word)
  );

  // mode follows the class of the registered instruction.
  always_comb begin
    if (!busy_q) begin
      state = ucode_pkg::seq_idle;
    end else if (rom_in_control) begin
      state = ucode_pkg::seq_rom;
    end else begin
      state = ucode_pkg::seq_direct;
    end
  end

  always_comb begin
    uop.opcode = op_q;
    if (state == ucode_pkg::seq_rom) begin
      uop.kind = word.kind;
      uop.last = word.last;
    end else begin
      uop.kind = ucode_pkg::uop_direct;
      uop.last = 1'b1;
    end
  end

  assign accept   = in_valid && ready_q;
  assign send     = (state != ucode_pkg::seq_idle) && (cred_q != '0);  // stall without credit.
  assign done     = send && uop.last;
  assign in_ready = ready_q;
  assign tx.valid = send;
  assign tx.uop   = uop;

  always_comb begin
    cred_d = cred_q;
    if (send) cred_d = cred_d - ucode_pkg::credit_t'(1);
    if (tx.credit_return) cred_d = cred_d + ucode_pkg::credit_t'(1);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q  <= 1'b0;
      ready_q <= 1'b0;
      step_q  <= '0;
      cred_q  <= ucode_pkg::credit_t'(ucode_pkg::queue_depth);
    end else begin
      cred_q  <= cred_d;
      ready_q <= !accept && (done || !busy_q);  // rises the cycle after last is sent.
      if (accept) begin
        busy_q <= 1'b1;
        step_q <= '0;
      end else if (done) begin
        busy_q <= 1'b0;
        step_q <= '0;
      end else if (send) begin
        step_q <= step_q + ucode_pkg::step_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q   <= in_opcode;
      size_q <= in_sizeop;
    end
  end

  // the queue must never hand back more credits than it was given.
  a_credit_bound: assert property (@(posedge clk) disable iff (rst)
    cred_q <= ucode_pkg::credit_t'(ucode_pkg::queue_depth));

endmodule

//--- source/uop_out_queue.sv
`timescale 1ns/10ps

module uop_out_queue (
  input  logic            clk,
  input  logic            rst,
  uop_credit_if.receiver  rx,
  output logic            out_valid,
  output ucode_pkg::uop_t out_uop,
  input  logic            out_credit
);

  ucode_pkg::uop_t    mem [ucode_pkg::queue_depth];
  ucode_pkg::ptr_t    wr_ptr_q;
  ucode_pkg::ptr_t    rd_ptr_q;
  ucode_pkg::credit_t count_q;     // entries held.
  ucode_pkg::credit_t ext_cred_q;  // credits granted by the consumer.
  logic               pop;

  assign pop              = (count_q != '0) && (ext_cred_q != '0);
  assign out_valid        = pop;
  assign out_uop          = mem[rd_ptr_q];
  assign rx.credit_return = pop;  // each pop frees a slot for the sequencer.

  always_ff @(posedge clk) begin
    if (rx.valid) begin
      mem[wr_ptr_q] <= rx.uop;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      ext_cred_q <= ucode_pkg::credit_t'(ucode_pkg::out_credits);
    end else begin
      // pointers wrap on their own, depth is a power of two.
      if (rx.valid) wr_ptr_q <= wr_ptr_q + ucode_pkg::ptr_t'(1);
      if (pop) rd_ptr_q <= rd_ptr_q + ucode_pkg::ptr_t'(1);

      case ({rx.valid, pop})
        2'b10: count_q <= count_q + ucode_pkg::credit_t'(1);
        2'b01: count_q <= count_q - ucode_pkg::credit_t'(1);
        default: ;
      endcase

      case ({pop, out_credit})
        2'b10: ext_cred_q <= ext_cred_q - ucode_pkg::credit_t'(1);
        2'b01: ext_cred_q <= ext_cred_q + ucode_pkg::credit_t'(1);
        default: ;
      endcase
    end
  end

  // holds only if the sequencer keeps to its credit count.
  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    rx.valid |-> count_q != ucode_pkg::credit_t'(ucode_pkg::queue_depth));

  a_ext_credit_bound: assert property (@(posedge clk) disable iff (rst)
    ext_cred_q <= ucode_pkg::credit_t'(ucode_pkg::out_credits));

endmodule

//--- source/decode_ucode_top.sv
`timescale 1ns/10ps

module decode_ucode_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           in_valid,
  input  logic [ucode_pkg::opcode_w-1:0] in_opcode,
  input  logic                           in_sizeop,
  output logic                           in_ready,
  output logic                           out_valid,
  output ucode_pkg::uop_t                out_uop,
  input  logic                           out_credit
);

  uop_credit_if uop_link ();  // sequencer to queue.

  ucode_sequencer u_seq (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_opcode (in_opcode),
    .in_sizeop (in_sizeop),
    .in_ready  (in_ready),
    .tx        (uop_link)
  );

  uop_out_queue u_queue (
    .clk        (clk),
    .rst        (rst),
    .rx         (uop_link),
    .out_valid  (out_valid),
    .out_uop    (out_uop),
    .out_credit (out_credit)
  );

endmodule

//--- tests/tb_decode_ucode.sv
`timescale 1ns/10ps

module tb_decode_ucode;

  localparam int clk_half    = 4;
  localparam int reset_len   = 16;
  localparam int max_instr   = 64;
  localparam int wd_per_line = 200;  // watchdog cycles per stimulus line.

  logic                           clk;
  logic                           rst;
  logic                           in_valid;
  logic [ucode_pkg::opcode_w-1:0] in_opcode;
  logic                           in_sizeop;
  logic                           in_ready;
  logic                           out_valid;
  ucode_pkg::uop_t                out_uop;
  logic                           out_credit;

  // one row per instruction of the stimulus file.
  logic [ucode_pkg::opcode_w-1:0]    op_tab    [max_instr];
  logic                              size_tab  [max_instr];
  logic                              rom_tab   [max_instr];
  logic [ucode_pkg::rom_entry_w-1:0] entry_tab [max_instr];
  int                                count_tab [max_instr];
  ucode_pkg::uop_kind_e              kind_tab  [max_instr][4];

  ucode_pkg::uop_kind_e              exp_kind_q [$];
  logic [ucode_pkg::opcode_w-1:0]    exp_op_q   [$];
  logic                              exp_last_q [$];

  int   num_instr     = 0;
  int   total_uops    = 0;
  int   accepted      = 0;
  int   uops_seen     = 0;
  int   credits_back  = 0;
  int   reset_cycles  = 0;
  int   run_cycles    = 0;
  int   credit_rate   = 4;
  int   decode_idx    = 0;
  logic decode_pending = 1'b0;

  decode_ucode_top dut (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_opcode  (in_opcode),
    .in_sizeop  (in_sizeop),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_uop    (out_uop),
    .out_credit (out_credit)
  );

  always #clk_half clk = ~clk;

  task automatic stop_run();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic fail_with(input string msg);
    $display("%s (t=%0t)", msg, $time);
    stop_run();
  endtask

  task automatic check_kind(input string name, input ucode_pkg::uop_kind_e exp,
                            input ucode_pkg::uop_kind_e act);
    if (exp !== act) begin
      $display("ERR t=%0t %s expected %s got %s (%0d)", $time, name, exp.name(), act.name(),
               act);
      stop_run();
    end
  endtask

  task automatic check_opcode(input string name, input logic [ucode_pkg::opcode_w-1:0] exp,
                              input logic [ucode_pkg::opcode_w-1:0] act);
    if (exp !== act) begin
      $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_last(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("ERR t=%0t %s expected %b got %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_rom_use(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("ERR t=%0t %s expected %b got %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_entry(input string name, input logic [ucode_pkg::rom_entry_w-1:0] exp,
                             input logic [ucode_pkg::rom_entry_w-1:0] act);
    if (exp !== act) begin
      $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic load_stimulus();
    int                                fd;
    int                                n;
    string                             line;
    logic [ucode_pkg::opcode_w-1:0]    op;
    logic [ucode_pkg::rom_entry_w-1:0] ent;
    int                                size_v;
    int                                rom_v;
    int                                cnt;
    int                                k [4];
    fd = $fopen("tests/ucode_stimulus.txt", "r");
    if (fd == 0) fail_with("cannot open tests/ucode_stimulus.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%h %d %d %h %d %d %d %d %d", op, size_v, rom_v, ent, cnt,
                  k[0], k[1], k[2], k[3]);
      if (n != 9 || cnt < 1 || cnt > 4) fail_with("malformed line in stimulus file");
      if (rom_v == 0 && (cnt != 1 || k[0] != 0)) fail_with("direct line lists rom micro-ops");
      if (num_instr == max_instr) fail_with("stimulus file holds too many instructions");
      op_tab[num_instr]    = op;
      size_tab[num_instr]  = size_v[0];
      rom_tab[num_instr]   = rom_v[0];
      entry_tab[num_instr] = ent;
      count_tab[num_instr] = cnt;
      for (int s = 0; s < 4; s++) kind_tab[num_instr][s] = ucode_pkg::uop_kind_e'(k[s]);
      total_uops += cnt;
      num_instr++;
    end
    $fclose(fd);
  endtask

  // queue the micro-ops an accepted instruction must produce.
  task automatic expect_instr(input int idx);
    for (int s = 0; s < count_tab[idx]; s++) begin
      exp_kind_q.push_back(kind_tab[idx][s]);
      exp_op_q.push_back(op_tab[idx]);
      exp_last_q.push_back(s == count_tab[idx] - 1);
    end
  endtask

  // what the mid-cycle monitor sees transfers on the next rising edge.
  always @(negedge clk) begin
    if (rst) begin
      reset_cycles++;
      if (reset_cycles > 1 && in_ready !== 1'b0) fail_with("in_ready high during reset");
      if (reset_cycles > 1 && out_valid !== 1'b0) fail_with("out_valid high during reset");
    end else begin
      run_cycles++;
      if (run_cycles == 2 && in_ready !== 1'b1) fail_with("in_ready did not rise after reset");
      if (decode_pending) begin
        check_rom_use("rom_in_control", rom_tab[decode_idx], dut.u_seq.rom_in_control);
        check_entry("rom_control", entry_tab[decode_idx], dut.u_seq.rom_control);
        decode_pending = 1'b0;
      end
      if (in_valid && in_ready) begin
        if (accepted >= num_instr) fail_with("more instructions accepted than driven");
        expect_instr(accepted);
        decode_idx     = accepted;
        decode_pending = 1'b1;
        accepted++;
      end
      if (out_valid) begin
        if (accepted == 0) fail_with("out_valid rose before any instruction was accepted");
        if (exp_kind_q.size() == 0) fail_with("micro-op seen with none expected");
        uops_seen++;
        if (uops_seen > credits_back + ucode_pkg::out_credits) begin
          fail_with("out_valid without an external credit held");
        end
        check_kind("out_uop.kind", exp_kind_q.pop_front(), out_uop.kind);
        check_opcode("out_uop.opcode", exp_op_q.pop_front(), out_uop.opcode);
        check_last("out_uop.last", exp_last_q.pop_front(), out_uop.last);
      end
      if (out_credit) credits_back++;
    end
  end

  // consumer hands back credits only for micro-ops it has taken.
  always @(posedge clk) begin
    #1;
    if (($urandom % 32) == 0) credit_rate = 1 + ($urandom % 8);  // starved or plentiful phases.
    out_credit = !rst && (uops_seen > credits_back) && (($urandom % 8) < credit_rate);
  end

  initial begin
    wait (num_instr > 0);
    repeat ((num_instr + 1) * wd_per_line) @(posedge clk);
    $display("run timed out after %0d cycles", (num_instr + 1) * wd_per_line);
    stop_run();
  end

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    in_valid   = 1'b0;
    in_opcode  = '0;
    in_sizeop  = 1'b0;
    out_credit = 1'b0;
    void'($urandom(32'h4428a628));
    load_stimulus();
    if (num_instr == 0) fail_with("stimulus file holds no instructions");
    repeat (reset_len) @(posedge clk);
    #1 rst = 1'b0;
    repeat (4) @(posedge clk);  // out_valid must stay low while idle.
    #1;
    for (int i = 0; i < num_instr; i++) begin
      if (($urandom % 5) == 0) begin
        in_valid = 1'b0;
        @(posedge clk);
        #1;
      end
      in_valid  = 1'b1;
      in_opcode = op_tab[i];
      in_sizeop = size_tab[i];
      @(negedge clk);
      while (!in_ready) @(negedge clk);
      @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
    wait (uops_seen == total_uops);
    repeat (20) @(posedge clk);  // any extra micro-op shows up here.
    @(negedge clk);
    if (in_ready !== 1'b1) begin
      fail_with("sequencer did not return to idle after its last micro-op");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

//--- tests/ucode_stimulus.txt
# opcode(hex) sizeop rom entry(hex) count kind0 kind1 kind2 kind3
# kinds: 0 direct 1 load 2 store 3 alu 4 push 5 pop 6 jump
e812 1 1 8 2 4 6 0 0
e834 0 1 9 3 3 4 6 0
ff10 1 1 a 3 1 4 6 0
ff25 0 1 b 4 1 3 4 6
9a00 0 1 3 3 4 4 6 0
9a7e 1 0 0 1 0 0 0 0
cf00 0 1 2 4 5 5 5 6
cf01 1 0 0 1 0 0 0 0
c300 0 1 4 2 5 6 0 0
c3ff 1 0 0 1 0 0 0 0
cb00 0 1 5 3 5 5 6 0
cb11 1 0 0 1 0 0 0 0
c208 0 1 6 3 5 3 6 0
c208 1 0 0 1 0 0 0 0
ca40 0 1 7 4 5 5 3 6
ca40 1 0 0 1 0 0 0 0
9000 0 0 0 1 0 0 0 0
8b45 1 0 0 1 0 0 0 0
0105 0 0 0 1 0 0 0 0
c100 0 0 0 1 0 0 0 0
c600 0 0 0 1 0 0 0 0
eb00 0 0 0 1 0 0 0 0
fe00 0 0 0 1 0 0 0 0
e800 0 1 9 3 3 4 6 0
ffff 1 1 a 3 1 4 6 0
ca02 0 1 7 4 5 5 3 6
c3c3 0 1 4 2 5 6 0 0
1234 1 0 0 1 0 0 0 0
9a9a 0 1 3 3 4 4 6 0
cfcf 0 1 2 4 5 5 5 6

//--- sources.f
source/ucode_pkg.sv
source/opcode_rom_control_cloud.sv
source/ucode_rom.sv
source/uop_credit_if.sv
source/ucode_sequencer.sv
source/uop_out_queue.sv
source/decode_ucode_top.sv
tests/tb_decode_ucode.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_ucode
RTL_TOP   ?= decode_ucode_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
SEED_ARGS ?= +verilator+seed+1
VFLAGS    ?= --timing --assert --timescale 1ns/10ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(BUILD_DIR)
